// ==== rv_core.f ====
rtl/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/rv_core.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --assert --timing -f rv_core.f --top-module rv_core_tb -Mdir obj_dir

run:
	@out=$$(./obj_dir/Vrv_core_tb); echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -f rv_core.f --top-module rv_core_tb

clean:
	rm -rf obj_dir

// ==== test/rv_core_tb.sv ====
/* rv_core testbench
   program table, fetch responder with random delay, retire checks */
`timescale 1ns/1ps
module rv_core_tb import rv_core_pkg::*; ;
    localparam logic [31:0] RESET_PC = 32'h8000_0000;

    logic        clk = 1'b0;
    logic        reset;
    logic        imem_req;
    xlen_t       imem_addr;
    logic        imem_rvalid;
    xlen_t       imem_rdata;
    logic        retire_valid;
    retire_t     retire;
    logic [31:0] imem [64];
    logic [31:0] lfsr = 32'h6505_70d8;
    logic [31:0] pc_fill = RESET_PC;
    string       row_name[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic        exp_we[$];
    logic [31:0] exp_wdata[$];
    int          errors = 0;
    int          checks = 0;
    logic        table_ready = 1'b0;

    rv_core #(.RESET_PC(RESET_PC), .DMEM_WORDS(256)) UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // unused slots hold an unknown opcode that varies with the address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ addr[26:2], 7'h7f};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] k;
        k = (addr - RESET_PC) >> 2;
        return (k < 64) ? imem[k] : fill_word(addr);
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic [4:0] rd,
                           input logic we, input logic [31:0] wdata);
        imem[(pc_fill - RESET_PC) >> 2] = word;
        row_name.push_back(name);
        exp_pc.push_back(pc_fill);
        exp_rd.push_back(rd);
        exp_we.push_back(we);
        exp_wdata.push_back(wdata);
        pc_fill = pc_fill + 4;
    endtask

    task automatic skip_slot();  // branch shadow, never retires
        pc_fill = pc_fill + 4;
    endtask

    initial begin
        for (int k = 0; k < 64; k++) imem[k] = fill_word(RESET_PC + 4 * k);
        add_row("addi", enc_i(12'd5, 0, 3'b000, 1, 7'b0010011), 1, 1, 32'd5);
        add_row("addi_neg", enc_i(-12'sd3, 0, 3'b000, 2, 7'b0010011), 2, 1, 32'hffff_fffd);
        add_row("add", enc_r(7'h00, 2, 1, 3'b000, 3), 3, 1, 32'd2);
        add_row("sub", enc_r(7'h20, 2, 1, 3'b000, 4), 4, 1, 32'd8);
        add_row("slt", enc_r(7'h00, 1, 2, 3'b010, 5), 5, 1, 32'd1);
        add_row("sltu", enc_r(7'h00, 1, 2, 3'b011, 6), 6, 1, 32'd0);
        add_row("xor", enc_r(7'h00, 2, 1, 3'b100, 7), 7, 1, 32'hffff_fff8);
        add_row("or", enc_r(7'h00, 2, 1, 3'b110, 8), 8, 1, 32'hffff_fffd);
        add_row("and", enc_r(7'h00, 2, 1, 3'b111, 9), 9, 1, 32'd5);
        add_row("sll", enc_r(7'h00, 1, 1, 3'b001, 10), 10, 1, 32'h0000_00a0);
        add_row("srl", enc_r(7'h00, 1, 2, 3'b101, 11), 11, 1, 32'h07ff_ffff);
        add_row("sra", enc_r(7'h20, 1, 2, 3'b101, 12), 12, 1, 32'hffff_ffff);
        add_row("lui", {20'h12345, 5'd13, 7'b0110111}, 13, 1, 32'h1234_5000);
        add_row("auipc", {20'h00001, 5'd14, 7'b0010111}, 14, 1, pc_fill + 32'h1000);
        add_row("sw", enc_s(12'd32, 2, 0, 3'b010), 0, 0, 0);
        add_row("lw", enc_i(12'd32, 0, 3'b010, 15, 7'b0000011), 15, 1, 32'hffff_fffd);
        add_row("addi_80", enc_i(12'h080, 0, 3'b000, 16, 7'b0010011), 16, 1, 32'h80);
        add_row("sb", enc_s(12'd41, 16, 0, 3'b000), 0, 0, 0);
        add_row("lb", enc_i(12'd41, 0, 3'b000, 17, 7'b0000011), 17, 1, 32'hffff_ff80);
        add_row("lbu", enc_i(12'd41, 0, 3'b100, 18, 7'b0000011), 18, 1, 32'h0000_0080);
        add_row("sh", enc_s(12'd50, 2, 0, 3'b001), 0, 0, 0);
        add_row("lh", enc_i(12'd50, 0, 3'b001, 19, 7'b0000011), 19, 1, 32'hffff_fffd);
        add_row("lhu", enc_i(12'd50, 0, 3'b101, 20, 7'b0000011), 20, 1, 32'h0000_fffd);
        // x1 = 5, x2 = -3; taken branches jump over one slot
        add_row("beq_t", enc_b(13'd8, 1, 1, 3'b000), 0, 0, 0);
        skip_slot();
        add_row("beq_n", enc_b(13'd8, 2, 1, 3'b000), 0, 0, 0);
        add_row("bne_t", enc_b(13'd8, 2, 1, 3'b001), 0, 0, 0);
        skip_slot();
        add_row("bne_n", enc_b(13'd8, 1, 1, 3'b001), 0, 0, 0);
        add_row("blt_t", enc_b(13'd8, 1, 2, 3'b100), 0, 0, 0);
        skip_slot();
        add_row("blt_n", enc_b(13'd8, 2, 1, 3'b100), 0, 0, 0);
        add_row("bge_t", enc_b(13'd8, 2, 1, 3'b101), 0, 0, 0);
        skip_slot();
        add_row("bge_n", enc_b(13'd8, 1, 2, 3'b101), 0, 0, 0);
        add_row("bltu_t", enc_b(13'd8, 2, 1, 3'b110), 0, 0, 0);
        skip_slot();
        add_row("bltu_n", enc_b(13'd8, 1, 2, 3'b110), 0, 0, 0);
        add_row("bgeu_t", enc_b(13'd8, 1, 2, 3'b111), 0, 0, 0);
        skip_slot();
        add_row("bgeu_n", enc_b(13'd8, 2, 1, 3'b111), 0, 0, 0);
        add_row("jal", enc_j(21'd8, 21), 21, 1, pc_fill + 4);
        skip_slot();
        add_row("auipc_0", {20'h0, 5'd22, 7'b0010111}, 22, 1, pc_fill);
        add_row("jalr", enc_i(12'd13, 22, 3'b000, 23, 7'b1100111), 23, 1, pc_fill + 4);
        skip_slot();  // odd offset 13 lands here + 4 after bit 0 clears
        add_row("addi_x0", enc_i(12'd7, 0, 3'b000, 0, 7'b0010011), 0, 1, 32'd7);
        add_row("add_x0", enc_r(7'h00, 1, 0, 3'b000, 24), 24, 1, 32'd5);
        add_row("unknown", 32'h0000_050b, 0, 0, 0);
        add_row("after_unk", enc_i(12'd1, 0, 3'b000, 25, 7'b0010011), 25, 1, 32'd1);
        table_ready = 1'b1;
    end

    initial begin
        reset = 1'b1;
        imem_rvalid = 1'b0;
        imem_rdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    // fetch responder, 0 to 3 idle cycles per request
    initial begin
        logic [1:0] idle;
        forever begin
            @(negedge clk);
            if (!reset && imem_req) begin
                lfsr = lfsr_next(lfsr);
                idle[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                idle[1] = lfsr[0];
                repeat (idle) @(posedge clk);
                @(posedge clk);
                imem_rvalid <= 1'b1;
                imem_rdata  <= word_at(imem_addr);
                @(posedge clk);
                imem_rvalid <= 1'b0;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (row_name.size() * (4 + 3 + 2) + 50 + 4) @(posedge clk);
        $display("watchdog expired before all instructions retired");
        $display("Regression failed");
        $finish;
    end

    initial begin
        wait (table_ready);
        for (int i = 0; i < row_name.size(); i++) begin
            do @(negedge clk); while (!retire_valid);
            checks++;
            assert (retire.pc == exp_pc[i]) else begin
                $display("[FAIL] %s pc expected %h actual %h", row_name[i], exp_pc[i], retire.pc);
                errors++;
            end
            assert (retire.we == exp_we[i]) else begin
                $display("[FAIL] %s we expected %0d actual %0d", row_name[i], exp_we[i], retire.we);
                errors++;
            end
            if (exp_we[i]) begin  // rd and data only matter when writing
                assert (retire.rd == exp_rd[i]) else begin
                    $display("[FAIL] %s rd expected %0d actual %0d", row_name[i], exp_rd[i],
                             retire.rd);
                    errors++;
                end
                assert (retire.wdata == exp_wdata[i]) else begin
                    $display("[FAIL] %s wdata expected %h actual %h", row_name[i],
                             exp_wdata[i], retire.wdata);
                    errors++;
                end
            end
        end
        $display("retires checked %0d, value errors %0d, assertion errors %0d",
                 checks, errors, UUT.chk.fail_count);
        if (errors == 0 && UUT.chk.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== test/rv_core_checker.sv ====
/* fetch port and retire timing checks
   bound into rv_core */
`timescale 1ns/1ps
module rv_core_checker import rv_core_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  imem_req,
    input xlen_t imem_addr,
    input logic  imem_rvalid,
    input logic  retire_valid
);
    int fail_count = 0;  // read by the testbench at the end

    // address held while a request is open
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        (imem_req && !imem_rvalid) |=> $stable(imem_addr))
        else begin $error("imem_addr changed during an open request"); fail_count++; end

    a_retire_latency: assert property (@(posedge clk) disable iff (reset)
        imem_rvalid |-> ##4 retire_valid)
        else begin $error("retire_valid not seen 4 cycles after imem_rvalid"); fail_count++; end

    // every retire traces back to a response, so none in or just after reset
    a_no_spurious_retire: assert property (@(posedge clk)
        retire_valid |-> $past(imem_rvalid, 4))
        else begin $error("retire_valid without a response 4 cycles before"); fail_count++; end

    a_req_drops: assert property (@(posedge clk) disable iff (reset)
        imem_rvalid |=> !imem_req)
        else begin $error("imem_req still high after the response"); fail_count++; end

endmodule

bind rv_core rv_core_checker chk (.*);

// ==== rtl/rv_core.sv ====
/* rv_core top level
   five-stage RV32I core with one instruction in flight */
`timescale 1ns/1ps
module rv_core import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC   = 32'h8000_0000,
    parameter int    DMEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    reset,
    output logic    imem_req,
    output xlen_t   imem_addr,
    input  logic    imem_rvalid,
    input  xlen_t   imem_rdata,
    output logic    retire_valid,
    output retire_t retire
);
    logic     redirect_valid;
    xlen_t    next_pc;
    logic     fetch_valid;
    inst_u    fetch_inst;
    xlen_t    fetch_pc;
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    logic     dec_valid;
    decode_t  dec;
    logic     exe_valid;
    exec_t    exe;
    logic     mem_valid;
    exec_t    mem_out;
    logic     wr_en;
    reg_idx_t wr_addr;
    xlen_t    wr_data;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .next_pc        (next_pc),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_rvalid    (imem_rvalid),
        .imem_rdata     (imem_rdata),
        .fetch_valid    (fetch_valid),
        .fetch_inst     (fetch_inst),
        .fetch_pc       (fetch_pc)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe       (exe)
    );

    memory_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_memory (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe       (exe),
        .mem_valid (mem_valid),
        .mem_out   (mem_out)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .reset          (reset),
        .mem_valid      (mem_valid),
        .mem_out        (mem_out),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .redirect_valid (redirect_valid),
        .next_pc        (next_pc),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

// ==== rtl/writeback_stage.sv ====
/* writeback stage
   register write, retire record and the redirect back to fetch */
`timescale 1ns/1ps
module writeback_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_valid,
    input  exec_t    mem_out,
    output logic     wr_en,
    output reg_idx_t wr_addr,
    output xlen_t    wr_data,
    output logic     redirect_valid,
    output xlen_t    next_pc,
    output logic     retire_valid,
    output retire_t  retire
);
    logic we;

    always_comb begin
        case (mem_out.opcode)
            OP, OP_IMM, LOAD, LUI, AUIPC, JAL, JALR: we = 1'b1;
            default: we = 1'b0;  // stores, branches, unknown
        endcase
    end

    assign wr_en   = mem_valid && we;
    assign wr_addr = mem_out.rd;
    assign wr_data = mem_out.result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) retire_valid <= 1'b0;
        else retire_valid <= mem_valid;
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            retire  <= '{pc: mem_out.pc, rd: mem_out.rd, we: we, wdata: mem_out.result};
            next_pc <= mem_out.next_pc;
        end
    end

    assign redirect_valid = retire_valid;  // fetch restarts as the instruction retires

endmodule

// ==== rtl/memory_stage.sv ====
/* memory stage
   small data RAM with byte-lane stores and extending loads */
`timescale 1ns/1ps
module memory_stage import rv_core_pkg::*; #(
    parameter int DMEM_WORDS = 256  // power of two
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  exe_valid,
    input  exec_t exe,
    output logic  mem_valid,
    output exec_t mem_out
);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    xlen_t            ram [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [1:0]       boff;
    logic [3:0]       be;
    xlen_t            wdata;
    xlen_t            rword;
    xlen_t            load_val;

    assign idx  = exe.result[IDX_W+1:2];  // wraps modulo ram size
    assign boff = exe.result[1:0];

    always_comb begin
        case (exe.funct3[1:0])
            2'b00: begin
                be    = 4'b0001 << boff;
                wdata = {4{exe.store_data[7:0]}};
            end
            2'b01: begin
                be    = 4'b0011 << {boff[1], 1'b0};
                wdata = {2{exe.store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = exe.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe.opcode == STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ram[idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    assign rword = ram[idx] >> {boff, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (exe.funct3)
            3'b000:  load_val = {{24{rword[7]}}, rword[7:0]};    // lb
            3'b001:  load_val = {{16{rword[15]}}, rword[15:0]};  // lh
            3'b100:  load_val = {24'b0, rword[7:0]};             // lbu
            3'b101:  load_val = {16'b0, rword[15:0]};            // lhu
            default: load_val = rword;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) mem_valid <= 1'b0;
        else mem_valid <= exe_valid;
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            mem_out <= exe;
            if (exe.opcode == LOAD) mem_out.result <= load_val;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
/* execute stage
   ALU, branch compare, next pc and link value */
`timescale 1ns/1ps
module execute_stage import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    dec_valid,
    input  decode_t dec,
    output logic    exe_valid,
    output exec_t   exe
);
    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t alu_res;
    xlen_t link;
    xlen_t next_pc;
    xlen_t result;
    logic  taken;

    // operand select
    always_comb begin
        alu_a = dec.rs1_val;
        alu_b = (dec.kind == R) ? dec.rs2_val : dec.imm;
        case (dec.opcode)
            LUI:                alu_a = '0;
            AUIPC, JAL, BRANCH: alu_a = dec.pc;
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            SUB:     alu_res = alu_a - alu_b;
            SLL:     alu_res = alu_a << alu_b[4:0];
            SLT:     alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            SLTU:    alu_res = {31'b0, alu_a < alu_b};
            XOR:     alu_res = alu_a ^ alu_b;
            SRL:     alu_res = alu_a >> alu_b[4:0];
            SRA:     alu_res = xlen_t'($signed(alu_a) >>> alu_b[4:0]);
            OR:      alu_res = alu_a | alu_b;
            AND:     alu_res = alu_a & alu_b;
            default: alu_res = alu_a + alu_b;
        endcase
    end

    // compares always on the register values
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (dec.rs1_val == dec.rs2_val);
            3'b001:  taken = (dec.rs1_val != dec.rs2_val);
            3'b100:  taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
            3'b101:  taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
            3'b110:  taken = (dec.rs1_val < dec.rs2_val);
            3'b111:  taken = (dec.rs1_val >= dec.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign link = dec.pc + 32'd4;

    always_comb begin
        next_pc = link;
        result  = alu_res;
        case (dec.opcode)
            BRANCH: next_pc = taken ? alu_res : link;
            JAL: begin
                next_pc = alu_res;
                result  = link;
            end
            JALR: begin
                next_pc = {alu_res[31:1], 1'b0};
                result  = link;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) exe_valid <= 1'b0;
        else exe_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe <= '{
                pc:         dec.pc,
                opcode:     dec.opcode,
                funct3:     dec.funct3,
                rd:         dec.rd,
                result:     result,
                store_data: dec.rs2_val,
                next_pc:    next_pc
            };
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
/* integer register file, 32 x 32 bits, x0 tied to zero */
`timescale 1ns/1ps
module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  xlen_t    wr_data
);
    xlen_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== rtl/decode_stage.sv ====
/* instruction decode
   builds kind, immediate and ALU op, and latches the operand values */
`timescale 1ns/1ps
module decode_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     fetch_valid,
    input  inst_u    fetch_inst,
    input  xlen_t    fetch_pc,
    output reg_idx_t rs1_addr,
    output reg_idx_t rs2_addr,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output logic     dec_valid,
    output decode_t  dec
);
    logic [31:0] w;  // raw word for the scattered B and J bits
    inst_kind_e  kind;
    xlen_t       imm;
    alu_op_e     alu_op;
    logic [6:0]  opc;

    assign w        = fetch_inst;
    assign opc      = fetch_inst.rtype.opcode;
    assign rs1_addr = fetch_inst.rtype.rs1;
    assign rs2_addr = fetch_inst.rtype.rs2;

    always_comb begin
        case (opc)
            OP:                 kind = R;
            OP_IMM, LOAD, JALR: kind = I;
            STORE:              kind = S;
            BRANCH:             kind = B;
            LUI, AUIPC:         kind = U;
            JAL:                kind = J;
            default:            kind = NONE;
        endcase
    end

    always_comb begin
        case (kind)
            I: imm = {{20{fetch_inst.itype.imm12[11]}}, fetch_inst.itype.imm12};
            S: imm = {{20{w[31]}}, fetch_inst.rtype.funct7, fetch_inst.rtype.rd};
            B: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U: imm = {w[31:12], 12'b0};
            J: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // non-ALU opcodes use ADD for address and target sums
    always_comb begin
        alu_op = ADD;
        if (opc == OP || opc == OP_IMM) begin
            case (fetch_inst.rtype.funct3)
                3'b000: alu_op = (kind == R && fetch_inst.rtype.funct7[5]) ? SUB : ADD;
                3'b001: alu_op = SLL;
                3'b010: alu_op = SLT;
                3'b011: alu_op = SLTU;
                3'b100: alu_op = XOR;
                3'b101: alu_op = fetch_inst.rtype.funct7[5] ? SRA : SRL;  // srai keeps bit 30 too
                3'b110: alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) dec_valid <= 1'b0;
        else dec_valid <= fetch_valid;
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec <= '{
                pc:      fetch_pc,
                kind:    kind,
                opcode:  opcode_e'(opc),
                funct3:  fetch_inst.rtype.funct3,
                alu_op:  alu_op,
                rd:      fetch_inst.rtype.rd,
                imm:     imm,
                rs1_val: rs1_data,
                rs2_val: rs2_data
            };
        end
    end

endmodule

// ==== rtl/fetch_stage.sv ====
/* instruction fetch
   holds the pc and runs one request at a time on the fetch port */
`timescale 1ns/1ps
module fetch_stage import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  redirect_valid,
    input  xlen_t next_pc,
    output logic  imem_req,
    output xlen_t imem_addr,
    input  logic  imem_rvalid,
    input  xlen_t imem_rdata,
    output logic  fetch_valid,
    output inst_u fetch_inst,
    output xlen_t fetch_pc
);
    typedef enum logic {
        ST_REQ,
        ST_WAIT_REDIR
    } fetch_state_e;

    fetch_state_e state;
    xlen_t        pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_REQ;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_REQ: if (imem_rvalid) state <= ST_WAIT_REDIR;
                ST_WAIT_REDIR: begin
                    if (redirect_valid) begin
                        state <= ST_REQ;
                        pc    <= next_pc;  // resolved by writeback
                    end
                end
                default: state <= ST_REQ;
            endcase
        end
    end

    assign imem_req  = (state == ST_REQ);
    assign imem_addr = pc;

    // response goes straight to decode, which registers it
    assign fetch_valid = (state == ST_REQ) && imem_rvalid;
    assign fetch_inst  = imem_rdata;
    assign fetch_pc    = pc;

endmodule

// ==== rtl/rv_core_pkg.sv ====
/* rv_core shared types
   opcodes, instruction views, stage records and ALU ops */
package rv_core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        R,
        I,
        S,
        B,
        U,
        J,
        NONE  // unknown opcode, retires as a no-op
    } inst_kind_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]  funct7;
        reg_idx_t    rs2;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } rtype_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } itype_view_t;

    // same word, two field layouts
    typedef union packed {
        rtype_view_t rtype;
        itype_view_t itype;
    } inst_u;

    typedef struct packed {
        xlen_t      pc;
        inst_kind_e kind;
        opcode_e    opcode;
        logic [2:0] funct3;
        alu_op_e    alu_op;
        reg_idx_t   rd;
        xlen_t      imm;
        xlen_t      rs1_val;
        xlen_t      rs2_val;
    } decode_t;

    typedef struct packed {
        xlen_t      pc;
        opcode_e    opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        xlen_t      result;      // ALU value, address, or load data after memory
        xlen_t      store_data;
        xlen_t      next_pc;
    } exec_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     we;
        xlen_t    wdata;
    } retire_t;

endpackage
